// ==== source/rdma_wr_pkg.sv ====
/*
 * Shared field widths, beat geometry and vector typedefs
 * for the RDMA write steering subsystem
 */
package rdma_wr_pkg;

  // --------------------------------------------------
  // Beat geometry
  // --------------------------------------------------

  // Data bits per beat
  parameter int DATA_BITS = 64;
  // One keep bit per data byte
  parameter int KEEP_BITS = DATA_BITS / 8;
  // Low length bits that select a byte inside a beat
  parameter int BEAT_LOG_BITS = $clog2(KEEP_BITS);

  // --------------------------------------------------
  // Request fields
  // --------------------------------------------------

  // Byte length of one write
  parameter int LEN_BITS = 16;
  // Process id
  parameter int PID_BITS = 6;
  // Virtual function id
  parameter int VFID_BITS = 4;

  typedef logic [LEN_BITS-1:0] len_t;
  typedef logic [PID_BITS-1:0] pid_t;
  typedef logic [VFID_BITS-1:0] vfid_t;

  // Queue pair number, vfid in the upper bits
  typedef logic [VFID_BITS+PID_BITS-1:0] qpn_t;

  // Beats per write, one extra bit for the round-up case
  typedef logic [LEN_BITS-BEAT_LOG_BITS:0] beats_t;

  typedef logic [DATA_BITS-1:0] beat_data_t;
  typedef logic [KEEP_BITS-1:0] beat_keep_t;

endpackage

// ==== source/fifo_queue.sv ====
/*
 * Generic valid/ready FIFO on a circular buffer
 * with occupancy count
 */
`timescale 1ns/1ps

module fifo_queue #(
  parameter int WIDTH = 8,
  parameter int DEPTH = 4
) (
  input  logic             aclk,
  input  logic             aresetn,
  // Write side
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [WIDTH-1:0] in_data,
  // Read side
  output logic             out_valid,
  input  logic             out_ready,
  output logic [WIDTH-1:0] out_data
);

  // Pointer needs at least one bit even for a single entry
  localparam int PTR_BITS = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_BITS = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]    mem [DEPTH];
  logic [PTR_BITS-1:0] wr_ptr;
  logic [PTR_BITS-1:0] rd_ptr;
  logic [CNT_BITS-1:0] count;
  logic                push;
  logic                pop;

  // Full blocks writes even when a read happens in the same cycle
  assign in_ready  = (count != CNT_BITS'(DEPTH));
  assign out_valid = (count != '0);
  // Oldest word, straight from the storage array
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  // --------------------------------------------------
  // Pointers and occupancy
  // --------------------------------------------------
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PTR_BITS'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count + CNT_BITS'(push) - CNT_BITS'(pop);
    end
  end

  // Storage array
  always_ff @(posedge aclk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

endmodule

// ==== source/wr_data_steer.sv ====
/*
 * Request acceptance, outstanding-request queue and
 * per-write data steering by beat count
 */
`timescale 1ns/1ps

module wr_data_steer #(
  parameter int N_OUTSTANDING = 8
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  // Write requests
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     req_host,
  input  rdma_wr_pkg::vfid_t       req_vfid,
  input  rdma_wr_pkg::pid_t        req_pid,
  input  rdma_wr_pkg::len_t        req_len,
  // Write data
  input  logic                     wr_tvalid,
  output logic                     wr_tready,
  input  rdma_wr_pkg::beat_data_t  wr_tdata,
  input  rdma_wr_pkg::beat_keep_t  wr_tkeep,
  input  logic                     wr_tlast,
  // Host path
  output logic                     hp_req_valid,
  input  logic                     hp_req_ready,
  output rdma_wr_pkg::vfid_t       hp_req_vfid,
  output rdma_wr_pkg::pid_t        hp_req_pid,
  output rdma_wr_pkg::len_t        hp_req_len,
  output logic                     hp_beat_valid,
  input  logic                     hp_beat_ready,
  output rdma_wr_pkg::beat_data_t  hp_beat_data,
  output rdma_wr_pkg::beat_keep_t  hp_beat_keep,
  output logic                     hp_beat_last,
  output logic                     hp_burst_done,
  // Send packer
  output logic                     sp_beat_valid,
  input  logic                     sp_beat_ready,
  output rdma_wr_pkg::beat_data_t  sp_beat_data,
  output logic                     sp_beat_last,
  output rdma_wr_pkg::vfid_t       sp_vfid,
  output rdma_wr_pkg::pid_t        sp_pid
);

  import rdma_wr_pkg::*;

  // Routing entry is host bit, vfid, pid and length
  localparam int OQ_WIDTH = 1 + VFID_BITS + PID_BITS + LEN_BITS;

  typedef enum logic {
    ST_IDLE,
    ST_STEER
  } state_t;

  state_t  state_q;
  state_t  state_d;

  logic    oq_in_valid;
  logic    oq_in_ready;
  logic    oq_out_valid;
  logic    oq_out_ready;
  logic    next_host;
  vfid_t   next_vfid;
  pid_t    next_pid;
  len_t    next_len;
  beats_t  next_beats;
  logic    load;

  // Current write
  logic    host_q;
  vfid_t   vfid_q;
  pid_t    pid_q;
  beats_t  beats_q;
  beats_t  beat_cnt;
  logic    beat_fire;
  logic    tr_done;

  // --------------------------------------------------
  // Request side
  // --------------------------------------------------

  // Host requests also need room in the host request queue
  assign req_ready    = oq_in_ready && (!req_host || hp_req_ready);
  assign oq_in_valid  = req_valid && (!req_host || hp_req_ready);
  assign hp_req_valid = req_valid && req_host && oq_in_ready;
  assign hp_req_vfid  = req_vfid;
  assign hp_req_pid   = req_pid;
  assign hp_req_len   = req_len;

  // Keeps steering in request order
  fifo_queue #(
    .WIDTH (OQ_WIDTH),
    .DEPTH (N_OUTSTANDING)
  ) outstanding_q_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (oq_in_valid),
    .in_ready  (oq_in_ready),
    .in_data   ({req_host, req_vfid, req_pid, req_len}),
    .out_valid (oq_out_valid),
    .out_ready (oq_out_ready),
    .out_data  ({next_host, next_vfid, next_pid, next_len})
  );

  // Beats = length / 8, rounded up
  assign next_beats = beats_t'(next_len[LEN_BITS-1:BEAT_LOG_BITS])
                    + beats_t'(next_len[BEAT_LOG_BITS-1:0] != '0);

  // --------------------------------------------------
  // Steering FSM
  // --------------------------------------------------
  assign beat_fire = wr_tvalid && wr_tready;
  // Ends on the counted beat, incoming last is not trusted
  assign tr_done   = beat_fire && (beat_cnt == beats_q - beats_t'(1));
  assign load      = oq_out_valid && oq_out_ready;

  always_comb begin
    state_d      = state_q;
    oq_out_ready = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (oq_out_valid) begin
          oq_out_ready = 1'b1;
          state_d      = ST_STEER;
        end
      end
      ST_STEER: begin
        // Chain straight into a waiting write
        if (tr_done) begin
          oq_out_ready = oq_out_valid;
          if (!oq_out_valid) begin
            state_d = ST_IDLE;
          end
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      state_q  <= ST_IDLE;
      host_q   <= 1'b0;
      beats_q  <= '0;
      beat_cnt <= '0;
    end else begin
      state_q <= state_d;
      if (load) begin
        host_q   <= next_host;
        beats_q  <= next_beats;
        beat_cnt <= '0;
      end else if (tr_done) begin
        beat_cnt <= '0;
      end else if (beat_fire) begin
        beat_cnt <= beat_cnt + beats_t'(1);
      end
    end
  end

  // Queue pair fields of the current write
  always_ff @(posedge aclk) begin
    if (load) begin
      vfid_q <= next_vfid;
      pid_q  <= next_pid;
    end
  end

  // --------------------------------------------------
  // Beat routing, no register on the path
  // --------------------------------------------------
  assign wr_tready     = (state_q == ST_STEER) && (host_q ? hp_beat_ready : sp_beat_ready);

  assign hp_beat_valid = (state_q == ST_STEER) && host_q && wr_tvalid;
  assign hp_beat_data  = wr_tdata;
  assign hp_beat_keep  = wr_tkeep;
  assign hp_beat_last  = wr_tlast;
  // Host path counts finished bursts from this
  assign hp_burst_done = tr_done && host_q;

  // Send side carries no keep
  assign sp_beat_valid = (state_q == ST_STEER) && !host_q && wr_tvalid;
  assign sp_beat_data  = wr_tdata;
  assign sp_beat_last  = wr_tlast;
  assign sp_vfid       = vfid_q;
  assign sp_pid        = pid_q;

endmodule

// ==== source/host_wr_path.sv ====
/*
 * Host write path with request and data queues,
 * store-and-forward release of requests
 */
`timescale 1ns/1ps

module host_wr_path #(
  parameter int N_OUTSTANDING = 8,
  parameter int DATA_DEPTH    = 32
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  // From steering
  input  logic                     hp_req_valid,
  output logic                     hp_req_ready,
  input  rdma_wr_pkg::vfid_t       hp_req_vfid,
  input  rdma_wr_pkg::pid_t        hp_req_pid,
  input  rdma_wr_pkg::len_t        hp_req_len,
  input  logic                     hp_beat_valid,
  output logic                     hp_beat_ready,
  input  rdma_wr_pkg::beat_data_t  hp_beat_data,
  input  rdma_wr_pkg::beat_keep_t  hp_beat_keep,
  input  logic                     hp_beat_last,
  input  logic                     hp_burst_done,
  // To the DMA engine
  output logic                     hreq_valid,
  input  logic                     hreq_ready,
  output rdma_wr_pkg::vfid_t       hreq_vfid,
  output rdma_wr_pkg::pid_t        hreq_pid,
  output rdma_wr_pkg::len_t        hreq_len,
  output logic                     hdata_tvalid,
  input  logic                     hdata_tready,
  output rdma_wr_pkg::beat_data_t  hdata_tdata,
  output rdma_wr_pkg::beat_keep_t  hdata_tkeep,
  output logic                     hdata_tlast
);

  import rdma_wr_pkg::*;

  // Bounded by queued requests
  localparam int DONE_BITS = $clog2(N_OUTSTANDING + 1);

  logic                 rq_out_valid;
  logic                 rq_out_ready;
  logic                 release_req;
  logic [DONE_BITS-1:0] done_cnt;

  fifo_queue #(
    .WIDTH (VFID_BITS + PID_BITS + LEN_BITS),
    .DEPTH (N_OUTSTANDING)
  ) req_q_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (hp_req_valid),
    .in_ready  (hp_req_ready),
    .in_data   ({hp_req_vfid, hp_req_pid, hp_req_len}),
    .out_valid (rq_out_valid),
    .out_ready (rq_out_ready),
    .out_data  ({hreq_vfid, hreq_pid, hreq_len})
  );

  // Data flows out freely, only requests wait
  fifo_queue #(
    .WIDTH (DATA_BITS + KEEP_BITS + 1),
    .DEPTH (DATA_DEPTH)
  ) data_q_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (hp_beat_valid),
    .in_ready  (hp_beat_ready),
    .in_data   ({hp_beat_data, hp_beat_keep, hp_beat_last}),
    .out_valid (hdata_tvalid),
    .out_ready (hdata_tready),
    .out_data  ({hdata_tdata, hdata_tkeep, hdata_tlast})
  );

  // --------------------------------------------------
  // Release only with a whole burst buffered
  // --------------------------------------------------
  assign hreq_valid   = rq_out_valid && (done_cnt != '0);
  assign rq_out_ready = hreq_ready && (done_cnt != '0);
  assign release_req  = hreq_valid && hreq_ready;

  // Completed bursts not yet matched by a released request
  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      done_cnt <= '0;
    end else begin
      done_cnt <= done_cnt + DONE_BITS'(hp_burst_done) - DONE_BITS'(release_req);
    end
  end

endmodule

// ==== source/send_packer.sv ====
/*
 * Send-queue record builder and output record queue
 */
`timescale 1ns/1ps

module send_packer #(
  parameter int DATA_DEPTH = 32
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  // Beats of the current send write
  input  logic                     sp_beat_valid,
  output logic                     sp_beat_ready,
  input  rdma_wr_pkg::beat_data_t  sp_beat_data,
  input  logic                     sp_beat_last,
  input  rdma_wr_pkg::vfid_t       sp_vfid,
  input  rdma_wr_pkg::pid_t        sp_pid,
  // Send-queue records
  output logic                     rq_valid,
  input  logic                     rq_ready,
  output rdma_wr_pkg::qpn_t        rq_qpn,
  output logic                     rq_last,
  output rdma_wr_pkg::beat_data_t  rq_msg
);

  import rdma_wr_pkg::*;

  // Record layout is qpn, last, message
  localparam int REC_BITS = VFID_BITS + PID_BITS + 1 + DATA_BITS;

  qpn_t                qpn;
  logic [REC_BITS-1:0] rec_in;

  // --------------------------------------------------
  // Record build
  // --------------------------------------------------

  // vfid on top, pid below
  assign qpn    = {sp_vfid, sp_pid};
  assign rec_in = {qpn, sp_beat_last, sp_beat_data};

  // Absorbs stalls from the send queue
  fifo_queue #(
    .WIDTH (REC_BITS),
    .DEPTH (DATA_DEPTH)
  ) rec_q_i (
    .aclk      (aclk),
    .aresetn   (aresetn),
    .in_valid  (sp_beat_valid),
    .in_ready  (sp_beat_ready),
    .in_data   (rec_in),
    .out_valid (rq_valid),
    .out_ready (rq_ready),
    .out_data  ({rq_qpn, rq_last, rq_msg})
  );

endmodule

// ==== source/rdma_wr_mux_top.sv ====
/*
 * Top level of the RDMA write steering subsystem
 */
`timescale 1ns/1ps

module rdma_wr_mux_top #(
  parameter int N_OUTSTANDING = 8,
  parameter int DATA_DEPTH    = 32
) (
  input  logic                     aclk,
  input  logic                     aresetn,
  // User requests
  input  logic                     req_valid,
  output logic                     req_ready,
  input  logic                     req_host,
  input  rdma_wr_pkg::vfid_t       req_vfid,
  input  rdma_wr_pkg::pid_t        req_pid,
  input  rdma_wr_pkg::len_t        req_len,
  // User data
  input  logic                     wr_tvalid,
  output logic                     wr_tready,
  input  rdma_wr_pkg::beat_data_t  wr_tdata,
  input  rdma_wr_pkg::beat_keep_t  wr_tkeep,
  input  logic                     wr_tlast,
  // Host DMA request and data
  output logic                     hreq_valid,
  input  logic                     hreq_ready,
  output rdma_wr_pkg::vfid_t       hreq_vfid,
  output rdma_wr_pkg::pid_t        hreq_pid,
  output rdma_wr_pkg::len_t        hreq_len,
  output logic                     hdata_tvalid,
  input  logic                     hdata_tready,
  output rdma_wr_pkg::beat_data_t  hdata_tdata,
  output rdma_wr_pkg::beat_keep_t  hdata_tkeep,
  output logic                     hdata_tlast,
  // Send queue
  output logic                     rq_valid,
  input  logic                     rq_ready,
  output rdma_wr_pkg::qpn_t        rq_qpn,
  output logic                     rq_last,
  output rdma_wr_pkg::beat_data_t  rq_msg
);

  import rdma_wr_pkg::*;

  // Steering to host path
  logic       hp_req_valid;
  logic       hp_req_ready;
  vfid_t      hp_req_vfid;
  pid_t       hp_req_pid;
  len_t       hp_req_len;
  logic       hp_beat_valid;
  logic       hp_beat_ready;
  beat_data_t hp_beat_data;
  beat_keep_t hp_beat_keep;
  logic       hp_beat_last;
  logic       hp_burst_done;

  // Steering to send packer
  logic       sp_beat_valid;
  logic       sp_beat_ready;
  beat_data_t sp_beat_data;
  logic       sp_beat_last;
  vfid_t      sp_vfid;
  pid_t       sp_pid;

  wr_data_steer #(
    .N_OUTSTANDING (N_OUTSTANDING)
  ) steer_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .req_valid     (req_valid),
    .req_ready     (req_ready),
    .req_host      (req_host),
    .req_vfid      (req_vfid),
    .req_pid       (req_pid),
    .req_len       (req_len),
    .wr_tvalid     (wr_tvalid),
    .wr_tready     (wr_tready),
    .wr_tdata      (wr_tdata),
    .wr_tkeep      (wr_tkeep),
    .wr_tlast      (wr_tlast),
    .hp_req_valid  (hp_req_valid),
    .hp_req_ready  (hp_req_ready),
    .hp_req_vfid   (hp_req_vfid),
    .hp_req_pid    (hp_req_pid),
    .hp_req_len    (hp_req_len),
    .hp_beat_valid (hp_beat_valid),
    .hp_beat_ready (hp_beat_ready),
    .hp_beat_data  (hp_beat_data),
    .hp_beat_keep  (hp_beat_keep),
    .hp_beat_last  (hp_beat_last),
    .hp_burst_done (hp_burst_done),
    .sp_beat_valid (sp_beat_valid),
    .sp_beat_ready (sp_beat_ready),
    .sp_beat_data  (sp_beat_data),
    .sp_beat_last  (sp_beat_last),
    .sp_vfid       (sp_vfid),
    .sp_pid        (sp_pid)
  );

  host_wr_path #(
    .N_OUTSTANDING (N_OUTSTANDING),
    .DATA_DEPTH    (DATA_DEPTH)
  ) host_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .hp_req_valid  (hp_req_valid),
    .hp_req_ready  (hp_req_ready),
    .hp_req_vfid   (hp_req_vfid),
    .hp_req_pid    (hp_req_pid),
    .hp_req_len    (hp_req_len),
    .hp_beat_valid (hp_beat_valid),
    .hp_beat_ready (hp_beat_ready),
    .hp_beat_data  (hp_beat_data),
    .hp_beat_keep  (hp_beat_keep),
    .hp_beat_last  (hp_beat_last),
    .hp_burst_done (hp_burst_done),
    .hreq_valid    (hreq_valid),
    .hreq_ready    (hreq_ready),
    .hreq_vfid     (hreq_vfid),
    .hreq_pid      (hreq_pid),
    .hreq_len      (hreq_len),
    .hdata_tvalid  (hdata_tvalid),
    .hdata_tready  (hdata_tready),
    .hdata_tdata   (hdata_tdata),
    .hdata_tkeep   (hdata_tkeep),
    .hdata_tlast   (hdata_tlast)
  );

  send_packer #(
    .DATA_DEPTH (DATA_DEPTH)
  ) send_i (
    .aclk          (aclk),
    .aresetn       (aresetn),
    .sp_beat_valid (sp_beat_valid),
    .sp_beat_ready (sp_beat_ready),
    .sp_beat_data  (sp_beat_data),
    .sp_beat_last  (sp_beat_last),
    .sp_vfid       (sp_vfid),
    .sp_pid        (sp_pid),
    .rq_valid      (rq_valid),
    .rq_ready      (rq_ready),
    .rq_qpn        (rq_qpn),
    .rq_last       (rq_last),
    .rq_msg        (rq_msg)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * Testbench clock and active-low reset generator
 */
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 40,
  parameter int RESET_CYCLES = 4
) (
  output logic aclk,
  output logic aresetn
);

  // Free-running clock
  initial begin
    aclk = 1'b0;
    forever #(PERIOD_NS / 2) aclk = ~aclk;
  end

  // Reset released on a falling edge, away from the sampling edge
  initial begin
    aresetn = 1'b0;
    repeat (RESET_CYCLES) @(posedge aclk);
    @(negedge aclk);
    aresetn = 1'b1;
  end

endmodule

// ==== verification/rdma_wr_mux_assertions.sv ====
/*
 * Concurrent protocol assertions bound to the top level
 */
`timescale 1ns/1ps

module rdma_wr_mux_assertions (
  input logic                     aclk,
  input logic                     aresetn,
  input logic                     req_valid,
  input logic                     req_ready,
  input logic                     wr_tvalid,
  input logic                     wr_tready,
  input logic                     wr_tlast,
  input logic                     hreq_valid,
  input logic                     hreq_ready,
  input rdma_wr_pkg::vfid_t       hreq_vfid,
  input rdma_wr_pkg::pid_t        hreq_pid,
  input rdma_wr_pkg::len_t        hreq_len,
  input logic                     hdata_tvalid,
  input logic                     hdata_tready,
  input rdma_wr_pkg::beat_data_t  hdata_tdata,
  input rdma_wr_pkg::beat_keep_t  hdata_tkeep,
  input logic                     hdata_tlast,
  input logic                     rq_valid,
  input logic                     rq_ready,
  input rdma_wr_pkg::qpn_t        rq_qpn,
  input logic                     rq_last,
  input rdma_wr_pkg::beat_data_t  rq_msg
);

  int fail_count = 0;
  // Accepted requests whose last beat has not passed yet
  int outstanding;

  always_ff @(posedge aclk or negedge aresetn) begin
    if (!aresetn) begin
      outstanding <= 0;
    end else begin
      outstanding <= outstanding + int'(req_valid && req_ready)
                   - int'(wr_tvalid && wr_tready && wr_tlast);
    end
  end

  // --------------------------------------------------
  // Reset and handshake rules
  // --------------------------------------------------
  valids_low_in_reset: assert property (@(posedge aclk)
    !aresetn |-> !hreq_valid && !hdata_tvalid && !rq_valid)
    else begin
      fail_count++;
      $error("output valid high during reset");
    end

  hreq_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    hreq_valid && !hreq_ready |=> hreq_valid && $stable({hreq_vfid, hreq_pid, hreq_len}))
    else begin
      fail_count++;
      $error("hreq dropped or changed before ready");
    end

  hdata_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    hdata_tvalid && !hdata_tready
      |=> hdata_tvalid && $stable({hdata_tdata, hdata_tkeep, hdata_tlast}))
    else begin
      fail_count++;
      $error("hdata dropped or changed before ready");
    end

  rq_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rq_valid && !rq_ready |=> rq_valid && $stable({rq_qpn, rq_last, rq_msg}))
    else begin
      fail_count++;
      $error("rq dropped or changed before ready");
    end

  // No data accepted without a pending request
  no_ready_when_idle: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_tready |-> outstanding > 0)
    else begin
      fail_count++;
      $error("wr_tready high with no request outstanding");
    end

endmodule

bind rdma_wr_mux_top rdma_wr_mux_assertions asrt_i (
  .aclk (aclk), .aresetn (aresetn),
  .req_valid (req_valid), .req_ready (req_ready),
  .wr_tvalid (wr_tvalid), .wr_tready (wr_tready), .wr_tlast (wr_tlast),
  .hreq_valid (hreq_valid), .hreq_ready (hreq_ready), .hreq_vfid (hreq_vfid),
  .hreq_pid (hreq_pid), .hreq_len (hreq_len),
  .hdata_tvalid (hdata_tvalid), .hdata_tready (hdata_tready),
  .hdata_tdata (hdata_tdata), .hdata_tkeep (hdata_tkeep), .hdata_tlast (hdata_tlast),
  .rq_valid (rq_valid), .rq_ready (rq_ready), .rq_qpn (rq_qpn),
  .rq_last (rq_last), .rq_msg (rq_msg)
);

// ==== verification/rdma_wr_mux_tb.sv ====
/*
 * Testbench for the RDMA write steering top level with
 * stimulus, reference model, output scoreboards and watchdog
 */
`timescale 1ns/1ps

module rdma_wr_mux_tb;

  import rdma_wr_pkg::*;

  localparam int CLK_PERIOD_NS = 40;
  localparam int N_OUTSTANDING = 8;
  localparam int DATA_DEPTH    = 32;
  localparam int MAX_LEN       = 100;
  // Beats of the longest write
  localparam int MAX_BEATS     = (MAX_LEN + 7) / 8;
  localparam int TOTAL_WRITES  = 12 + 12 + 40 + 40;
  localparam int TIMEOUT_NS    = TOTAL_WRITES * MAX_BEATS * 40 * CLK_PERIOD_NS;
  localparam int MODE_HOST     = 0;
  localparam int MODE_SEND     = 1;
  localparam int MODE_MIX      = 2;

  logic aclk;
  logic aresetn;
  logic req_valid, req_ready, req_host;
  vfid_t req_vfid;
  pid_t req_pid;
  len_t req_len;
  logic wr_tvalid, wr_tready, wr_tlast;
  beat_data_t wr_tdata;
  beat_keep_t wr_tkeep;
  logic hreq_valid, hreq_ready;
  vfid_t hreq_vfid;
  pid_t hreq_pid;
  len_t hreq_len;
  logic hdata_tvalid, hdata_tready, hdata_tlast;
  beat_data_t hdata_tdata;
  beat_keep_t hdata_tkeep;
  logic rq_valid, rq_ready, rq_last;
  qpn_t rq_qpn;
  beat_data_t rq_msg;

  int seed;
  bit bp_on;
  // Host bit of the beat on the data input
  logic beat_host;
  int value_errors;
  int other_errors;
  int beats_accepted;
  int host_done;
  int host_released;

  // Expected outputs in order and the write info handed to the data generator
  logic [VFID_BITS+PID_BITS+LEN_BITS-1:0]   exp_hreq[$];
  logic [DATA_BITS+KEEP_BITS:0]             exp_hbeat[$];
  logic [VFID_BITS+PID_BITS+DATA_BITS:0]    exp_rec[$];
  len_t pend_len[$];
  logic pend_host[$];
  qpn_t pend_qpn[$];

  tb_clock_gen #(
    .PERIOD_NS    (CLK_PERIOD_NS),
    .RESET_CYCLES (4)
  ) clk_gen_i (
    .aclk    (aclk),
    .aresetn (aresetn)
  );

  rdma_wr_mux_top #(
    .N_OUTSTANDING (N_OUTSTANDING),
    .DATA_DEPTH    (DATA_DEPTH)
  ) dut_i (
    .aclk (aclk), .aresetn (aresetn),
    .req_valid (req_valid), .req_ready (req_ready), .req_host (req_host),
    .req_vfid (req_vfid), .req_pid (req_pid), .req_len (req_len),
    .wr_tvalid (wr_tvalid), .wr_tready (wr_tready), .wr_tdata (wr_tdata),
    .wr_tkeep (wr_tkeep), .wr_tlast (wr_tlast),
    .hreq_valid (hreq_valid), .hreq_ready (hreq_ready), .hreq_vfid (hreq_vfid),
    .hreq_pid (hreq_pid), .hreq_len (hreq_len),
    .hdata_tvalid (hdata_tvalid), .hdata_tready (hdata_tready),
    .hdata_tdata (hdata_tdata), .hdata_tkeep (hdata_tkeep), .hdata_tlast (hdata_tlast),
    .rq_valid (rq_valid), .rq_ready (rq_ready), .rq_qpn (rq_qpn),
    .rq_last (rq_last), .rq_msg (rq_msg)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Bytes to beats where a partial beat counts as a whole one
  function automatic int beats_of_len(input len_t len);
    return (int'(len) + 7) / 8;
  endfunction

  // Queue pair number as vfid times 64 plus pid
  function automatic qpn_t qpn_of(input vfid_t vfid, input pid_t pid);
    return qpn_t'(int'(vfid) * (1 << PID_BITS) + int'(pid));
  endfunction

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      value_errors++;
      $display("[ERROR] %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  task automatic issue_requests(input int n, input int mode, input bit gaps);
    logic host;
    vfid_t vfid;
    pid_t pid;
    len_t len;
    for (int i = 0; i < n; i++) begin
      if (mode == MODE_MIX) host = ($random(seed) & 1) == 1;
      else host = (mode == MODE_HOST);
      vfid = vfid_t'($random(seed));
      pid  = pid_t'($random(seed));
      len  = len_t'($unsigned($random(seed)) % MAX_LEN + 1);
      @(negedge aclk);
      while (gaps && ($random(seed) & 3) == 0) begin
        req_valid = 1'b0;
        @(negedge aclk);
      end
      req_valid = 1'b1;
      req_host  = host;
      req_vfid  = vfid;
      req_pid   = pid;
      req_len   = len;
      if (host) exp_hreq.push_back({vfid, pid, len});
      pend_len.push_back(len);
      pend_host.push_back(host);
      pend_qpn.push_back(qpn_of(vfid, pid));
      @(posedge aclk);
      while (!req_ready) @(posedge aclk);
    end
    @(negedge aclk);
    req_valid = 1'b0;
  endtask

  // Beats of each write in request order with last on the counted final beat
  task automatic stream_beats(input int n, input bit gaps, input int hold);
    int nb;
    logic host;
    qpn_t qpn;
    beat_data_t data;
    beat_keep_t keep;
    logic last;
    repeat (hold) @(negedge aclk);
    for (int w = 0; w < n; w++) begin
      while (pend_len.size() == 0) begin
        @(negedge aclk);
        wr_tvalid = 1'b0;
      end
      nb   = beats_of_len(pend_len.pop_front());
      host = pend_host.pop_front();
      qpn  = pend_qpn.pop_front();
      for (int b = 0; b < nb; b++) begin
        @(negedge aclk);
        while (gaps && ($random(seed) & 7) == 0) begin
          wr_tvalid = 1'b0;
          @(negedge aclk);
        end
        data = {$random(seed), $random(seed)};
        keep = beat_keep_t'($random(seed));
        last = (b == nb - 1);
        wr_tvalid = 1'b1;
        wr_tdata  = data;
        wr_tkeep  = keep;
        wr_tlast  = last;
        beat_host = host;
        if (host) exp_hbeat.push_back({data, keep, last});
        else exp_rec.push_back({qpn, last, data});
        @(posedge aclk);
        while (!wr_tready) @(posedge aclk);
      end
    end
    @(negedge aclk);
    wr_tvalid = 1'b0;
  endtask

  // Output readies turn random while back-pressure is on
  task automatic drive_ready();
    forever begin
      @(negedge aclk);
      if (bp_on) begin
        hreq_ready   = ($random(seed) & 3) != 0;
        hdata_tready = ($random(seed) & 3) != 0;
        rq_ready     = ($random(seed) & 3) != 0;
      end else begin
        hreq_ready   = 1'b1;
        hdata_tready = 1'b1;
        rq_ready     = 1'b1;
      end
    end
  endtask

  task automatic run_phase(input int n, input int mode, input bit stress);
    bp_on = stress;
    // Held data lets requests fill the outstanding queue first
    fork
      issue_requests(n, mode, !stress);
      stream_beats(n, 1'b1, stress ? N_OUTSTANDING * 3 : 0);
    join
    while (exp_hreq.size() != 0 || exp_hbeat.size() != 0 || exp_rec.size() != 0) begin
      @(negedge aclk);
    end
    bp_on = 1'b0;
    repeat (4) @(negedge aclk);
    // Everything drained and the FSM back in idle
    check_value("hreq_valid", 64'(hreq_valid), 64'h0);
    check_value("hdata_tvalid", 64'(hdata_tvalid), 64'h0);
    check_value("rq_valid", 64'(rq_valid), 64'h0);
    check_value("wr_tready", 64'(wr_tready), 64'h0);
    check_value("host_released", 64'(host_released), 64'(host_done));
  endtask

  // --------------------------------------------------
  // Output compare
  // --------------------------------------------------
  always @(posedge aclk) begin : compare_outputs
    logic [VFID_BITS+PID_BITS+LEN_BITS-1:0] e_req;
    logic [DATA_BITS+KEEP_BITS:0]           e_beat;
    logic [VFID_BITS+PID_BITS+DATA_BITS:0]  e_rec;
    if (aresetn) begin
      if (beats_accepted == 0 && (hreq_valid || hdata_tvalid || rq_valid)) begin
        other_errors++;
        $display("An output valid rose before any write data was accepted");
      end
      // Store-and-forward check sees only beats accepted at earlier edges
      if (hreq_valid && hreq_ready) begin
        if (host_released >= host_done) begin
          other_errors++;
          $display("A host request was released before all of its data was accepted");
        end
        host_released++;
        if (exp_hreq.size() == 0) begin
          other_errors++;
          $display("An unexpected host request appeared");
        end else begin
          e_req = exp_hreq.pop_front();
          check_value("hreq_vfid", 64'(hreq_vfid), 64'(e_req[25:22]));
          check_value("hreq_pid", 64'(hreq_pid), 64'(e_req[21:16]));
          check_value("hreq_len", 64'(hreq_len), 64'(e_req[15:0]));
        end
      end
      if (wr_tvalid && wr_tready) begin
        beats_accepted++;
        if (wr_tlast && beat_host) host_done++;
      end
      if (hdata_tvalid && hdata_tready) begin
        if (exp_hbeat.size() == 0) begin
          other_errors++;
          $display("An unexpected host data beat appeared");
        end else begin
          e_beat = exp_hbeat.pop_front();
          check_value("hdata_tdata", hdata_tdata, e_beat[72:9]);
          check_value("hdata_tkeep", 64'(hdata_tkeep), 64'(e_beat[8:1]));
          check_value("hdata_tlast", 64'(hdata_tlast), 64'(e_beat[0]));
        end
      end
      if (rq_valid && rq_ready) begin
        if (exp_rec.size() == 0) begin
          other_errors++;
          $display("An unexpected send record appeared");
        end else begin
          e_rec = exp_rec.pop_front();
          check_value("rq_qpn", 64'(rq_qpn), 64'(e_rec[74:65]));
          check_value("rq_last", 64'(rq_last), 64'(e_rec[64]));
          check_value("rq_msg", rq_msg, e_rec[63:0]);
        end
      end
    end
  end

  // Watchdog sized for every write at the longest length
  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("Timeout after %0d ns, the outputs did not drain", TIMEOUT_NS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : main
    int asrt_errors;
    seed = 40;
    bp_on = 1'b0;
    beat_host = 1'b0;
    value_errors = 0;
    other_errors = 0;
    beats_accepted = 0;
    host_done = 0;
    host_released = 0;
    req_valid = 1'b0;
    req_host = 1'b0;
    req_vfid = '0;
    req_pid = '0;
    req_len = '0;
    wr_tvalid = 1'b0;
    wr_tdata = '0;
    wr_tkeep = '0;
    wr_tlast = 1'b0;
    hreq_ready = 1'b0;
    hdata_tready = 1'b0;
    rq_ready = 1'b0;
    fork
      drive_ready();
    join_none
    @(posedge aresetn);
    repeat (2) @(negedge aclk);
    run_phase(12, MODE_HOST, 1'b0);
    run_phase(12, MODE_SEND, 1'b0);
    run_phase(40, MODE_MIX, 1'b0);
    // Random stalls on all outputs
    run_phase(40, MODE_MIX, 1'b1);
    asrt_errors = dut_i.asrt_i.fail_count;
    $display("Result: %0d value mismatches, %0d other failures, %0d assertion failures",
             value_errors, other_errors, asrt_errors);
    if (value_errors + other_errors + asrt_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== all.f ====
source/rdma_wr_pkg.sv
source/fifo_queue.sv
source/wr_data_steer.sv
source/host_wr_path.sv
source/send_packer.sv
source/rdma_wr_mux_top.sv
verification/tb_clock_gen.sv
verification/rdma_wr_mux_assertions.sv
verification/rdma_wr_mux_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator; pass only if the log holds the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module rdma_wr_mux_tb \
  -f all.f -o rdma_wr_mux_sim > build.log 2>&1 \
  && ./obj_dir/rdma_wr_mux_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "NO ERRORS" sim.log 2>/dev/null \
  && echo "Simulation passed" \
  || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
